// File: hw/isa_pkg.sv
package isa_pkg;

    localparam int WORD_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int OPC_WIDTH      = 6;
    localparam int IMM_WIDTH      = 16;

    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [OPC_WIDTH-1:0]      opcode_t;

    // instruction fields
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 26;
    localparam int RD_MSB  = 25;
    localparam int RD_LSB  = 21;
    localparam int RJ_MSB  = 20;
    localparam int RJ_LSB  = 16;
    localparam int RK_MSB  = 15;
    localparam int RK_LSB  = 11;

    localparam opcode_t OP_NOP    = 6'd0;
    localparam opcode_t OP_ADD    = 6'd1;
    localparam opcode_t OP_SUB    = 6'd2;
    localparam opcode_t OP_AND    = 6'd3;
    localparam opcode_t OP_OR     = 6'd4;
    localparam opcode_t OP_XOR    = 6'd5;
    localparam opcode_t OP_ADDI   = 6'd6;
    localparam opcode_t OP_PCADDI = 6'd7;
    localparam opcode_t OP_LDW    = 6'd8;
    localparam opcode_t OP_STW    = 6'd9;

endpackage

// File: hw/pipeline_pkg.sv
package pipeline_pkg;

    localparam int ISSUE_WIDTH = 2;

    typedef struct packed {
        logic          valid;
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
    } fetch_slot_t;

    // decode buffer entry
    typedef struct packed {
        logic                     valid;
        isa_pkg::word_t           pc;
        isa_pkg::opcode_t         opcode;
        isa_pkg::reg_addr_t       rd;
        logic                     reg_write_en;
        logic [1:0]               reg_read_en;
        isa_pkg::reg_addr_t [1:0] reg_read_addr;
        isa_pkg::word_t           imm;
        logic                     is_mem;
        logic                     is_load;
    } id_dispatch_t;

    typedef struct packed {
        logic                 valid;
        isa_pkg::word_t       pc;
        isa_pkg::opcode_t     opcode;
        isa_pkg::reg_addr_t   rd;
        logic                 reg_write_en;
        isa_pkg::word_t [1:0] reg_data;
        isa_pkg::word_t       imm;
    } dispatch_ex_t;

    typedef struct packed {
        logic               reg_write_en;
        isa_pkg::reg_addr_t reg_write_addr;
        isa_pkg::word_t     reg_write_data;
    } forward_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        logic               reg_write_en;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t     data;
    } commit_t;

endpackage

// File: hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic clk,
    input  logic rst_n_i,
    input  pipeline_pkg::fetch_slot_t  [pipeline_pkg::ISSUE_WIDTH-1:0] fetch_i,
    input  logic [pipeline_pkg::ISSUE_WIDTH-1:0] issue_en_i,
    input  logic pause_dispatch_i,
    output pipeline_pkg::id_dispatch_t [pipeline_pkg::ISSUE_WIDTH-1:0] id_o,
    output logic fetch_stall_o
);

    logic [1:0] issued;
    logic [1:0] slot_valid;

    function automatic pipeline_pkg::id_dispatch_t decode(input pipeline_pkg::fetch_slot_t f);
        pipeline_pkg::id_dispatch_t d;
        isa_pkg::opcode_t op;
        op = f.inst[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB];
        d = '0;
        d.valid = f.valid;
        d.pc = f.pc;
        d.opcode = op;
        d.rd = f.inst[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
        d.reg_read_addr[0] = f.inst[isa_pkg::RJ_MSB:isa_pkg::RJ_LSB];
        d.reg_read_addr[1] = f.inst[isa_pkg::RK_MSB:isa_pkg::RK_LSB];
        d.imm = {{(isa_pkg::WORD_WIDTH - isa_pkg::IMM_WIDTH){f.inst[isa_pkg::IMM_WIDTH-1]}},
                 f.inst[isa_pkg::IMM_WIDTH-1:0]};
        case (op)
            isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR, isa_pkg::OP_XOR: begin
                d.reg_read_en = 2'b11;
                d.reg_write_en = 1'b1;
            end
            isa_pkg::OP_ADDI: begin
                d.reg_read_en = 2'b01;
                d.reg_write_en = 1'b1;
            end
            isa_pkg::OP_PCADDI: d.reg_write_en = 1'b1;
            isa_pkg::OP_LDW: begin
                d.reg_read_en = 2'b01;
                d.reg_write_en = 1'b1;
                d.is_mem = 1'b1;
                d.is_load = 1'b1;
            end
            isa_pkg::OP_STW: begin
                // store data comes from rd
                d.reg_read_en = 2'b11;
                d.reg_read_addr[1] = d.rd;
                d.is_mem = 1'b1;
            end
            isa_pkg::OP_NOP: ;
            default: d.opcode = isa_pkg::OP_NOP;
        endcase
        return d;
    endfunction

    assign slot_valid = {id_o[1].valid, id_o[0].valid};
    assign issued = pause_dispatch_i ? 2'b00 : issue_en_i;
    assign fetch_stall_o = |(slot_valid & ~issued);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_o[0].valid <= 1'b0;
            id_o[1].valid <= 1'b0;
        end else if (fetch_stall_o) begin
            id_o[0].valid <= slot_valid[0] & ~issued[0];
            id_o[1].valid <= slot_valid[1] & ~issued[1];
        end else begin
            id_o[0] <= decode(fetch_i[0]);
            id_o[1] <= decode(fetch_i[1]);
        end
    end

    a_issue_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        (issue_en_i & ~slot_valid) == 2'b00);

endmodule

// File: hw/dispatch.sv
`timescale 1ns/1ps

module dispatch (
    input  logic clk,
    input  logic rst_n_i,
    input  pipeline_pkg::id_dispatch_t [pipeline_pkg::ISSUE_WIDTH-1:0] id_i,
    output isa_pkg::reg_addr_t [3:0] rf_raddr_o,
    input  isa_pkg::word_t     [3:0] rf_rdata_i,
    input  pipeline_pkg::forward_t [pipeline_pkg::ISSUE_WIDTH-1:0] ex_pf_i,
    input  logic [pipeline_pkg::ISSUE_WIDTH-1:0] ex_load_i,
    input  pipeline_pkg::forward_t [pipeline_pkg::ISSUE_WIDTH-1:0] mem_pf_i,
    input  pipeline_pkg::forward_t [pipeline_pkg::ISSUE_WIDTH-1:0] wb_pf_i,
    output logic [pipeline_pkg::ISSUE_WIDTH-1:0] issue_en_o,
    output logic pause_dispatch_o,
    output pipeline_pkg::dispatch_ex_t [pipeline_pkg::ISSUE_WIDTH-1:0] ex_o
);

    logic [1:0] inst_valid;
    logic [1:0] issue_go;
    logic mem_inst;
    logic data_relate;
    pipeline_pkg::dispatch_ex_t [pipeline_pkg::ISSUE_WIDTH-1:0] ex_d;

    function automatic logic fwd_hit(input pipeline_pkg::forward_t f, input isa_pkg::reg_addr_t a);
        return f.reg_write_en && f.reg_write_addr == a;
    endfunction

    assign inst_valid = {id_i[1].valid, id_i[0].valid};
    assign mem_inst = id_i[0].is_mem || id_i[1].is_mem;
    assign data_relate = id_i[0].reg_write_en && id_i[0].rd != '0
        && ((id_i[1].reg_read_en[0] && id_i[1].reg_read_addr[0] == id_i[0].rd)
        ||  (id_i[1].reg_read_en[1] && id_i[1].reg_read_addr[1] == id_i[0].rd));

    // older slot goes alone when pairing is not allowed
    assign issue_en_o = (&inst_valid && !mem_inst && !data_relate) ? 2'b11 :
                        inst_valid[0] ? 2'b01 : inst_valid[1] ? 2'b10 : 2'b00;
    assign issue_go = pause_dispatch_o ? 2'b00 : issue_en_o;

    // load in EX feeding any valid slot
    always_comb begin
        pause_dispatch_o = 1'b0;
        for (int s = 0; s < 2; s++) begin
            for (int r = 0; r < 2; r++) begin
                for (int l = 0; l < 2; l++) begin
                    if (id_i[s].valid && id_i[s].reg_read_en[r] && ex_load_i[l]
                        && ex_pf_i[l].reg_write_addr != '0
                        && ex_pf_i[l].reg_write_addr == id_i[s].reg_read_addr[r]) begin
                        pause_dispatch_o = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            ex_d[s].valid = issue_go[s];
            ex_d[s].pc = id_i[s].pc;
            ex_d[s].opcode = id_i[s].opcode;
            ex_d[s].rd = id_i[s].rd;
            ex_d[s].reg_write_en = issue_go[s] & id_i[s].reg_write_en;
            ex_d[s].imm = id_i[s].imm;
            for (int r = 0; r < 2; r++) begin
                rf_raddr_o[2*s+r] = id_i[s].reg_read_addr[r];
                // lowest priority first, later sources override
                ex_d[s].reg_data[r] = rf_rdata_i[2*s+r];
                for (int l = 0; l < 2; l++) begin
                    if (fwd_hit(wb_pf_i[l], id_i[s].reg_read_addr[r])) begin
                        ex_d[s].reg_data[r] = wb_pf_i[l].reg_write_data;
                    end
                end
                for (int l = 0; l < 2; l++) begin
                    if (fwd_hit(mem_pf_i[l], id_i[s].reg_read_addr[r])) begin
                        ex_d[s].reg_data[r] = mem_pf_i[l].reg_write_data;
                    end
                end
                for (int l = 0; l < 2; l++) begin
                    if (fwd_hit(ex_pf_i[l], id_i[s].reg_read_addr[r])) begin
                        ex_d[s].reg_data[r] = ex_pf_i[l].reg_write_data;
                    end
                end
                if (id_i[s].reg_read_addr[r] == '0) begin
                    ex_d[s].reg_data[r] = '0;
                end
                if (!id_i[s].reg_read_en[r]) begin
                    ex_d[s].reg_data[r] = id_i[s].imm;
                end
            end
            if (id_i[s].opcode == isa_pkg::OP_PCADDI) begin
                ex_d[s].reg_data[0] = id_i[s].pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int l = 0; l < 2; l++) begin
                ex_o[l].valid <= 1'b0;
                ex_o[l].reg_write_en <= 1'b0;
            end
        end else begin
            ex_o <= ex_d;
        end
    end

    a_in_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        id_i[0].valid && !pause_dispatch_o |=> ex_o[0].valid);

endmodule

// File: hw/execute_unit.sv
`timescale 1ns/1ps

module execute_unit #(
    parameter int DMEM_WORDS = 64
) (
    input  logic clk,
    input  logic rst_n_i,
    input  pipeline_pkg::dispatch_ex_t [pipeline_pkg::ISSUE_WIDTH-1:0] ex_i,
    output pipeline_pkg::forward_t [pipeline_pkg::ISSUE_WIDTH-1:0] ex_pf_o,
    output logic [pipeline_pkg::ISSUE_WIDTH-1:0] ex_load_o,
    output pipeline_pkg::forward_t [pipeline_pkg::ISSUE_WIDTH-1:0] mem_pf_o,
    output isa_pkg::word_t [pipeline_pkg::ISSUE_WIDTH-1:0] mem_pc_o,
    output logic [pipeline_pkg::ISSUE_WIDTH-1:0] mem_valid_o
);

    localparam int AW = $clog2(DMEM_WORDS);

    isa_pkg::word_t dmem [DMEM_WORDS];
    isa_pkg::word_t load_q;
    isa_pkg::word_t mem_addr;
    logic [1:0] lane_mem;
    logic store_en;
    pipeline_pkg::forward_t [1:0] mem_q;
    logic [1:0] load_q_lane;

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            lane_mem[l] = ex_i[l].valid
                && (ex_i[l].opcode == isa_pkg::OP_LDW || ex_i[l].opcode == isa_pkg::OP_STW);
            ex_load_o[l] = ex_i[l].valid && ex_i[l].opcode == isa_pkg::OP_LDW;
            ex_pf_o[l].reg_write_en = ex_i[l].valid && ex_i[l].reg_write_en;
            ex_pf_o[l].reg_write_addr = ex_i[l].rd;
            // ADDI and PCADDI arrive with imm and pc already in place
            case (ex_i[l].opcode)
                isa_pkg::OP_SUB: ex_pf_o[l].reg_write_data = ex_i[l].reg_data[0] - ex_i[l].reg_data[1];
                isa_pkg::OP_AND: ex_pf_o[l].reg_write_data = ex_i[l].reg_data[0] & ex_i[l].reg_data[1];
                isa_pkg::OP_OR:  ex_pf_o[l].reg_write_data = ex_i[l].reg_data[0] | ex_i[l].reg_data[1];
                isa_pkg::OP_XOR: ex_pf_o[l].reg_write_data = ex_i[l].reg_data[0] ^ ex_i[l].reg_data[1];
                default:         ex_pf_o[l].reg_write_data = ex_i[l].reg_data[0] + ex_i[l].reg_data[1];
            endcase
        end
    end

    // memory port follows the lane holding the load or store
    assign mem_addr = ex_i[lane_mem[1]].reg_data[0] + ex_i[lane_mem[1]].imm;
    assign store_en = lane_mem[1] ? ex_i[1].opcode == isa_pkg::OP_STW
                                  : lane_mem[0] && ex_i[0].opcode == isa_pkg::OP_STW;

    always_ff @(posedge clk) begin
        if (store_en) begin
            dmem[mem_addr[AW-1:0]] <= ex_i[lane_mem[1]].reg_data[1];
        end
        load_q <= dmem[mem_addr[AW-1:0]];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_q[0].reg_write_en <= 1'b0;
            mem_q[1].reg_write_en <= 1'b0;
            mem_valid_o <= '0;
        end else begin
            mem_q <= ex_pf_o;
            load_q_lane <= ex_load_o;
            mem_valid_o <= {ex_i[1].valid, ex_i[0].valid};
            mem_pc_o <= {ex_i[1].pc, ex_i[0].pc};
        end
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            mem_pf_o[l] = mem_q[l];
            if (load_q_lane[l]) begin
                mem_pf_o[l].reg_write_data = load_q;
            end
        end
    end

    a_one_mem_lane: assert property (@(posedge clk) disable iff (!rst_n_i) !(&lane_mem));

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic clk,
    input  isa_pkg::reg_addr_t [3:0] raddr_i,
    output isa_pkg::word_t     [3:0] rdata_o,
    input  pipeline_pkg::forward_t [pipeline_pkg::ISSUE_WIDTH-1:0] wr_i
);

    isa_pkg::word_t regs [32];

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata_o[p] = regs[raddr_i[p]];
        end
    end

    // lane 1 written last so it wins on a clash
    always_ff @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            if (wr_i[l].reg_write_en && wr_i[l].reg_write_addr != '0) begin
                regs[wr_i[l].reg_write_addr] <= wr_i[l].reg_write_data;
            end
        end
    end

endmodule

// File: hw/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit (
    input  logic clk,
    input  logic rst_n_i,
    input  pipeline_pkg::forward_t [pipeline_pkg::ISSUE_WIDTH-1:0] mem_pf_i,
    input  isa_pkg::word_t [pipeline_pkg::ISSUE_WIDTH-1:0] mem_pc_i,
    input  logic [pipeline_pkg::ISSUE_WIDTH-1:0] mem_valid_i,
    output pipeline_pkg::forward_t [pipeline_pkg::ISSUE_WIDTH-1:0] wb_pf_o,
    output pipeline_pkg::commit_t [pipeline_pkg::ISSUE_WIDTH-1:0] commit_o
);

    isa_pkg::word_t [1:0] pc_q;
    logic [1:0] valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_pf_o[0].reg_write_en <= 1'b0;
            wb_pf_o[1].reg_write_en <= 1'b0;
            valid_q <= '0;
        end else begin
            wb_pf_o <= mem_pf_i;
            valid_q <= mem_valid_i;
            pc_q <= mem_pc_i;
        end
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            commit_o[l].valid = valid_q[l];
            commit_o[l].pc = pc_q[l];
            commit_o[l].reg_write_en = wb_pf_o[l].reg_write_en;
            commit_o[l].rd = wb_pf_o[l].reg_write_addr;
            commit_o[l].data = wb_pf_o[l].reg_write_data;
        end
    end

endmodule

// File: hw/dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core #(
    parameter int DMEM_WORDS = 64
) (
    input  logic clk,
    input  logic rst_n_i,
    input  pipeline_pkg::fetch_slot_t [pipeline_pkg::ISSUE_WIDTH-1:0] fetch_i,
    output logic fetch_stall_o,
    output pipeline_pkg::commit_t [pipeline_pkg::ISSUE_WIDTH-1:0] commit_o
);

    pipeline_pkg::id_dispatch_t [pipeline_pkg::ISSUE_WIDTH-1:0] id;
    pipeline_pkg::dispatch_ex_t [pipeline_pkg::ISSUE_WIDTH-1:0] ex;
    pipeline_pkg::forward_t [pipeline_pkg::ISSUE_WIDTH-1:0] ex_pf;
    pipeline_pkg::forward_t [pipeline_pkg::ISSUE_WIDTH-1:0] mem_pf;
    pipeline_pkg::forward_t [pipeline_pkg::ISSUE_WIDTH-1:0] wb_pf;
    isa_pkg::word_t [pipeline_pkg::ISSUE_WIDTH-1:0] mem_pc;
    isa_pkg::reg_addr_t [3:0] rf_raddr;
    isa_pkg::word_t [3:0] rf_rdata;
    logic [pipeline_pkg::ISSUE_WIDTH-1:0] issue_en;
    logic [pipeline_pkg::ISSUE_WIDTH-1:0] ex_load;
    logic [pipeline_pkg::ISSUE_WIDTH-1:0] mem_valid;
    logic pause_dispatch;

    inst_decoder u_decoder (.clk, .rst_n_i, .fetch_i, .issue_en_i(issue_en),
        .pause_dispatch_i(pause_dispatch), .id_o(id), .fetch_stall_o);

    dispatch u_dispatch (.clk, .rst_n_i, .id_i(id), .rf_raddr_o(rf_raddr),
        .rf_rdata_i(rf_rdata), .ex_pf_i(ex_pf), .ex_load_i(ex_load), .mem_pf_i(mem_pf),
        .wb_pf_i(wb_pf), .issue_en_o(issue_en), .pause_dispatch_o(pause_dispatch), .ex_o(ex));

    execute_unit #(.DMEM_WORDS(DMEM_WORDS)) u_execute (.clk, .rst_n_i, .ex_i(ex),
        .ex_pf_o(ex_pf), .ex_load_o(ex_load), .mem_pf_o(mem_pf), .mem_pc_o(mem_pc),
        .mem_valid_o(mem_valid));

    reg_file u_reg_file (.clk, .raddr_i(rf_raddr), .rdata_o(rf_rdata), .wr_i(wb_pf));

    writeback_unit u_writeback (.clk, .rst_n_i, .mem_pf_i(mem_pf), .mem_pc_i(mem_pc),
        .mem_valid_i(mem_valid), .wb_pf_o(wb_pf), .commit_o);

endmodule

// File: sim/tb_dual_issue_core.sv
`timescale 1ns/1ps

module tb_dual_issue_core;

    localparam int DMEM_WORDS = 64;
    // preload, directed and random packets
    localparam int NUM_PACKETS = 16 + 32 + 2 + 1 + 5 + 4 + 200;
    localparam int TIMEOUT_CYCLES = NUM_PACKETS * 8 + 100;

    logic clk;
    logic rst_n_i;
    pipeline_pkg::fetch_slot_t [1:0] fetch_i;
    logic fetch_stall_o;
    pipeline_pkg::commit_t [1:0] commit_o;

    pipeline_pkg::commit_t exp_q [$];
    isa_pkg::word_t arch_regs [32];
    isa_pkg::word_t arch_mem [DMEM_WORDS];
    isa_pkg::word_t next_pc;
    logic [31:0] lfsr_state;
    int cycle_count;
    int pair_commits;

    dual_issue_core #(.DMEM_WORDS(DMEM_WORDS)) UUT (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .fetch_i(fetch_i),
        .fetch_stall_o(fetch_stall_o),
        .commit_o(commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic isa_pkg::word_t enc_i(input isa_pkg::opcode_t op,
            input isa_pkg::reg_addr_t rd, input isa_pkg::reg_addr_t rj, input logic [15:0] imm);
        return {op, rd, rj, imm};
    endfunction

    function automatic isa_pkg::word_t enc_r(input isa_pkg::opcode_t op,
            input isa_pkg::reg_addr_t rd, input isa_pkg::reg_addr_t rj,
            input isa_pkg::reg_addr_t rk);
        return {op, rd, rj, rk, 11'd0};
    endfunction

    task automatic check_commit(input pipeline_pkg::commit_t got, input pipeline_pkg::commit_t exp);
        if (got.pc !== exp.pc || got.reg_write_en !== exp.reg_write_en || got.rd !== exp.rd
            || (exp.reg_write_en && got.data !== exp.data)) begin
            report_failure($sformatf("** Error at %0t: commit pc %h rd %0d we %b data %h, %s",
                $time, got.pc, got.rd, got.reg_write_en, got.data,
                $sformatf("expected pc %h rd %0d we %b data %h",
                    exp.pc, exp.rd, exp.reg_write_en, exp.data)));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_failure($sformatf("** Error at %0t: %s is %0d, expected %0d",
                $time, what, got, exp));
        end
    endtask

    // architectural reference, program order
    task automatic model_exec(input isa_pkg::word_t pc, input isa_pkg::word_t inst);
        pipeline_pkg::commit_t c;
        isa_pkg::opcode_t op;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t imm;
        isa_pkg::word_t res;
        int unsigned addr;
        op = inst[31:26];
        rd = inst[25:21];
        a = arch_regs[inst[20:16]];
        b = arch_regs[inst[15:11]];
        imm = {{16{inst[15]}}, inst[15:0]};
        addr = (a + imm) % DMEM_WORDS;
        res = '0;
        c.valid = 1'b1;
        c.pc = pc;
        c.rd = rd;
        c.reg_write_en = 1'b1;
        case (op)
            isa_pkg::OP_ADD:    res = a + b;
            isa_pkg::OP_SUB:    res = a - b;
            isa_pkg::OP_AND:    res = a & b;
            isa_pkg::OP_OR:     res = a | b;
            isa_pkg::OP_XOR:    res = a ^ b;
            isa_pkg::OP_ADDI:   res = a + imm;
            isa_pkg::OP_PCADDI: res = pc + imm;
            isa_pkg::OP_LDW:    res = arch_mem[addr];
            isa_pkg::OP_STW: begin
                arch_mem[addr] = arch_regs[rd];
                c.reg_write_en = 1'b0;
            end
            default: c.reg_write_en = 1'b0;
        endcase
        c.data = res;
        if (c.reg_write_en && rd != '0) begin
            arch_regs[rd] = res;
        end
        exp_q.push_back(c);
    endtask

    // called at 1 ns past an edge, returns 1 ns past the accepting edge
    task automatic send_packet(input logic v0, input isa_pkg::word_t i0,
            input logic v1, input isa_pkg::word_t i1);
        pipeline_pkg::fetch_slot_t [1:0] pkt;
        pkt[0].valid = v0;
        pkt[0].pc = next_pc;
        pkt[0].inst = i0;
        pkt[1].valid = v1;
        pkt[1].pc = next_pc + 4;
        pkt[1].inst = i1;
        next_pc = next_pc + 8;
        if (v0) model_exec(pkt[0].pc, i0);
        if (v1) model_exec(pkt[1].pc, i1);
        fetch_i = pkt;
        while (fetch_stall_o) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        fetch_i = '0;
    endtask

    task automatic drain_pipeline();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic preload_state();
        isa_pkg::word_t w0;
        isa_pkg::word_t w1;
        for (int r = 1; r < 32; r += 2) begin
            w0 = enc_i(isa_pkg::OP_ADDI, r, 0, next_bits(16));
            w1 = enc_i(isa_pkg::OP_ADDI, r + 1, 0, next_bits(16));
            send_packet(1'b1, w0, r < 31, w1);
        end
        for (int a = 0; a < DMEM_WORDS; a += 2) begin
            w0 = enc_i(isa_pkg::OP_STW, 1 + a % 31, 0, a);
            w1 = enc_i(isa_pkg::OP_STW, 1 + (a + 1) % 31, 0, a + 1);
            send_packet(1'b1, w0, 1'b1, w1);
        end
        drain_pipeline();
    endtask

    task automatic test_independent_pair();
        int pairs_before;
        pairs_before = pair_commits;
        send_packet(1'b1, enc_i(isa_pkg::OP_ADDI, 1, 0, 16'h0011),
                    1'b1, enc_i(isa_pkg::OP_ADDI, 2, 0, 16'hfffd));
        check_level(fetch_stall_o, 1'b0, "fetch_stall_o after first pair");
        send_packet(1'b1, enc_r(isa_pkg::OP_ADD, 3, 1, 2), 1'b1, enc_r(isa_pkg::OP_SUB, 4, 1, 2));
        check_level(fetch_stall_o, 1'b0, "fetch_stall_o after second pair");
        drain_pipeline();
        check_count(pair_commits - pairs_before, 2, "paired commits");
    endtask

    task automatic test_dependent_pair();
        int pairs_before;
        pairs_before = pair_commits;
        send_packet(1'b1, enc_i(isa_pkg::OP_ADDI, 1, 0, 16'h0005),
                    1'b1, enc_r(isa_pkg::OP_ADD, 2, 1, 1));
        check_level(fetch_stall_o, 1'b1, "fetch_stall_o with slot 1 waiting");
        @(posedge clk);
        #1;
        check_level(fetch_stall_o, 1'b0, "fetch_stall_o once slot 1 issues");
        drain_pipeline();
        check_count(pair_commits - pairs_before, 0, "paired commits");
    endtask

    task automatic test_forwarding();
        send_packet(1'b1, enc_i(isa_pkg::OP_ADDI, 5, 0, 16'd100),
                    1'b1, enc_i(isa_pkg::OP_ADDI, 6, 0, 16'hfff9));
        send_packet(1'b1, enc_r(isa_pkg::OP_ADD, 7, 5, 6), 1'b1, enc_r(isa_pkg::OP_OR, 8, 0, 0));
        send_packet(1'b1, enc_r(isa_pkg::OP_SUB, 9, 5, 7), 1'b1, enc_r(isa_pkg::OP_AND, 10, 6, 6));
        send_packet(1'b1, enc_r(isa_pkg::OP_XOR, 11, 6, 8),
                    1'b1, enc_i(isa_pkg::OP_ADDI, 0, 5, 16'd55));
        send_packet(1'b1, enc_r(isa_pkg::OP_ADD, 12, 0, 5), 1'b1, enc_r(isa_pkg::OP_OR, 13, 0, 0));
        drain_pipeline();
    endtask

    task automatic test_memory();
        send_packet(1'b1, enc_i(isa_pkg::OP_ADDI, 20, 0, 16'h1234),
                    1'b1, enc_i(isa_pkg::OP_ADDI, 21, 0, 16'd12));
        send_packet(1'b1, enc_i(isa_pkg::OP_STW, 20, 21, 16'd3),
                    1'b1, enc_i(isa_pkg::OP_LDW, 22, 0, 16'd15));
        send_packet(1'b1, enc_r(isa_pkg::OP_ADD, 23, 22, 22),
                    1'b1, enc_i(isa_pkg::OP_PCADDI, 24, 0, 16'h0040));
        // pair could go together, only the load in EX holds it
        check_level(fetch_stall_o, 1'b1, "fetch_stall_o on load-use");
        send_packet(1'b1, enc_i(isa_pkg::OP_LDW, 25, 0, 16'd15),
                    1'b1, enc_r(isa_pkg::OP_ADD, 26, 25, 20));
        drain_pipeline();
    endtask

    task automatic test_random_stream();
        isa_pkg::word_t w0;
        isa_pkg::word_t w1;
        logic v0;
        logic v1;
        for (int p = 0; p < 200; p++) begin
            v0 = next_bits(1);
            v1 = next_bits(1);
            w0 = {6'(next_bits(4) % 10), 26'(next_bits(26))};
            w1 = {6'(next_bits(4) % 10), 26'(next_bits(26))};
            send_packet(v0, w0, v1, w1);
        end
        drain_pipeline();
    endtask

    // commits checked in program order, slot 0 first
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (commit_o[0].valid && commit_o[1].valid) pair_commits++;
            for (int l = 0; l < 2; l++) begin
                if (commit_o[l].valid === 1'b1) begin
                    if (exp_q.size() == 0) begin
                        report_failure("a commit appeared with no instruction left to retire");
                    end else begin
                        check_commit(commit_o[l], exp_q.pop_front());
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles with %0d commits still missing",
                cycle_count, exp_q.size()));
        end
    end

    initial begin
        rst_n_i = 1'b0;
        fetch_i = '0;
        next_pc = 32'h0000_1000;
        lfsr_state = 32'h28c5;
        cycle_count = 0;
        pair_commits = 0;
        for (int r = 0; r < 32; r++) begin
            arch_regs[r] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        check_level(commit_o[0].valid, 1'b0, "commit slot 0 valid after reset");
        check_level(commit_o[1].valid, 1'b0, "commit slot 1 valid after reset");
        check_level(fetch_stall_o, 1'b0, "fetch_stall_o after reset");
        preload_state();
        test_independent_pair();
        test_dependent_pair();
        test_forwarding();
        test_memory();
        test_random_stream();
        // idle cycles catch any stray commit
        repeat (5) @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

// File: dual_issue_core.f
hw/isa_pkg.sv
hw/pipeline_pkg.sv
hw/inst_decoder.sv
hw/dispatch.sv
hw/execute_unit.sv
hw/reg_file.sv
hw/writeback_unit.sv
hw/dual_issue_core.sv
sim/tb_dual_issue_core.sv

// File: Bender.yml
package:
  name: dual_issue_core

sources:
  - hw/isa_pkg.sv
  - hw/pipeline_pkg.sv
  - hw/inst_decoder.sv
  - hw/dispatch.sv
  - hw/execute_unit.sv
  - hw/reg_file.sv
  - hw/writeback_unit.sv
  - hw/dual_issue_core.sv
  - target: simulation
    files:
      - sim/tb_dual_issue_core.sv
